/* hw/flow_core_pkg.sv */
package flow_core_pkg;

    // one code or data byte
    typedef logic [7:0] byte_t;

    // program memory address
    typedef logic [15:0] code_addr_t;

    // data memory address and stack pointer
    typedef logic [7:0] data_addr_t;

    // which byte of an instruction is on rom_byte
    // phase_b3 always marks the last slot of an instruction,
    // so a two-byte instruction goes straight from phase_op to phase_b3
    typedef enum logic [1:0] {
        phase_op,
        phase_b2,
        phase_b3
    } phase_t;

    // data read stall
    typedef enum logic {
        stall_run,
        stall_read
    } stall_t;

    // decoded opcode class of one window slot
    typedef enum logic [2:0] {
        cls_other,
        cls_ajmp,
        cls_acall,
        cls_ljmp,
        cls_lcall,
        cls_sjmp,
        cls_ret
    } op_class_t;

    // full opcodes
    localparam byte_t op_ljmp  = 8'h02;
    localparam byte_t op_lcall = 8'h12;
    localparam byte_t op_ret   = 8'h22;
    localparam byte_t op_reti  = 8'h32;
    localparam byte_t op_sjmp  = 8'h80;

    // low five opcode bits of ajmp and acall
    // the top three bits carry target address bits 10:8
    localparam logic [4:0] ajmp_low  = 5'b00001;
    localparam logic [4:0] acall_low = 5'b10001;

endpackage

/* hw/fetch_sequencer.sv */
`timescale 1ns/10ps

module fetch_sequencer import flow_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_en,
    input  logic      ram_rd_en,
    input  logic      ram_rd_vld,
    input  op_class_t cls_a,
    output logic      advance,
    output phase_t    phase
);

    stall_t stall;
    phase_t phase_next;

    // ram_rd_vld is a level held by the memory until the core moves on
    assign advance = cpu_en & ((stall == stall_run) | ram_rd_vld);

    always_comb begin
        phase_next = phase_op;
        case (phase)
            phase_op: begin
                case (cls_a)
                    // acall and ret are shorter but use the extra slots
                    // for the second push or pop
                    cls_ljmp, cls_lcall, cls_acall, cls_ret: begin
                        phase_next = phase_b2;
                    end
                    cls_ajmp, cls_sjmp: begin
                        phase_next = phase_b3;
                    end
                    default: begin
                        phase_next = phase_op;
                    end
                endcase
            end
            phase_b2: begin
                phase_next = phase_b3;
            end
            default: begin
                phase_next = phase_op;
            end
        endcase
    end

    // starts in a last slot so the first fetched byte is taken as an opcode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= phase_b3;
        end else if (advance) begin
            phase <= phase_next;
        end
    end

    // a read issued now blocks the next cycle until its data is valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stall <= stall_run;
        end else if (advance) begin
            stall <= ram_rd_en ? stall_read : stall_run;
        end
    end

    a_phase_legal: assert property (
        @(posedge clk) disable iff (rst)
        phase inside {phase_op, phase_b2, phase_b3}
    );

endmodule

/* hw/instr_window.sv */
`timescale 1ns/10ps

module instr_window import flow_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  phase_t    phase,
    input  byte_t     rom_byte,
    output byte_t     byte1,
    output byte_t     byte2,
    output op_class_t cls_a,
    output op_class_t cls_b,
    output op_class_t cls_c
);

    // previous and second-previous slot held an opcode
    logic op1;
    logic op2;

    function automatic op_class_t decode(input byte_t op);
        op_class_t cls;
        case (op)
            op_ljmp:         cls = cls_ljmp;
            op_lcall:        cls = cls_lcall;
            op_ret, op_reti: cls = cls_ret;
            op_sjmp:         cls = cls_sjmp;
            default: begin
                if (op[4:0] == ajmp_low) begin
                    cls = cls_ajmp;
                end else if (op[4:0] == acall_low) begin
                    cls = cls_acall;
                end else begin
                    cls = cls_other;
                end
            end
        endcase
        return cls;
    endfunction

    // raw bytes, operands are read from here as well
    always_ff @(posedge clk) begin
        if (advance) begin
            byte1 <= rom_byte;
            byte2 <= byte1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op1 <= 1'b0;
            op2 <= 1'b0;
        end else if (advance) begin
            op1 <= (phase == phase_op);
            op2 <= op1;
        end
    end

    // operand and dead slots decode as cls_other
    assign cls_a = (phase == phase_op) ? decode(rom_byte) : cls_other;
    assign cls_b = op1 ? decode(byte1) : cls_other;
    assign cls_c = op2 ? decode(byte2) : cls_other;

endmodule

/* hw/program_counter.sv */
`timescale 1ns/10ps

module program_counter import flow_core_pkg::*; #(
    parameter code_addr_t pc_reset = 16'h0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       advance,
    input  byte_t      rom_byte,
    input  byte_t      byte1,
    input  byte_t      byte2,
    input  op_class_t  cls_a,
    input  op_class_t  cls_b,
    input  op_class_t  cls_c,
    input  code_addr_t pop_addr,
    output code_addr_t pc,
    output logic       rom_en,
    output code_addr_t rom_addr
);

    code_addr_t rel_target;
    code_addr_t page_target;
    code_addr_t call_target;
    code_addr_t long_target;
    logic       hold_fetch;

    // pc already points past the operand here
    assign rel_target = pc + {{8{rom_byte[7]}}, rom_byte};

    // ajmp resolves while its operand is still on rom_byte
    assign page_target = {pc[15:11], byte1[7:5], rom_byte};

    // acall resolves one slot later in the cycle of its high byte push
    assign call_target = {pc[15:11], byte2[7:5], byte1};

    assign long_target = {byte1, rom_byte};

    always_comb begin
        if (cls_c == cls_ret) begin
            rom_addr = pop_addr;
        end else if ((cls_c == cls_ljmp) || (cls_c == cls_lcall)) begin
            rom_addr = long_target;
        end else if (cls_c == cls_acall) begin
            rom_addr = call_target;
        end else if (cls_b == cls_ajmp) begin
            rom_addr = page_target;
        end else if (cls_b == cls_sjmp) begin
            rom_addr = rel_target;
        end else begin
            rom_addr = pc;
        end
    end

    // no fetch during either pop of a return
    // and none while acall pushes its low byte
    assign hold_fetch = (cls_a == cls_ret) || (cls_b == cls_ret) || (cls_b == cls_acall);

    assign rom_en = advance & ~hold_fetch;

    // pc moves past each fetched byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= pc_reset;
        end else if (advance && !hold_fetch) begin
            pc <= rom_addr + 16'd1;
        end
    end

    a_fetch_needs_advance: assert property (
        @(posedge clk) disable iff (rst)
        rom_en |-> advance
    );

endmodule

/* hw/stack_unit.sv */
`timescale 1ns/10ps

module stack_unit import flow_core_pkg::*; #(
    parameter data_addr_t sp_reset = 8'h07
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       advance,
    input  code_addr_t pc,
    input  logic       rom_en,
    input  op_class_t  cls_a,
    input  op_class_t  cls_b,
    input  op_class_t  cls_c,
    input  byte_t      ram_rd_byte,
    output logic       ram_rd_en,
    output data_addr_t ram_rd_addr,
    output logic       ram_wr_en,
    output data_addr_t ram_wr_addr,
    output byte_t      ram_wr_byte,
    output code_addr_t pop_addr
);

    data_addr_t sp;
    byte_t      pop_high;
    byte_t      ret_low;
    logic       push_low;
    logic       push_high;
    logic       pop_first;
    logic       pop_second;

    // call pushes sit one and two slots after the opcode
    assign push_low  = (cls_b == cls_acall) || (cls_b == cls_lcall);
    assign push_high = (cls_c == cls_acall) || (cls_c == cls_lcall);

    // return pops sit in the opcode slot and the one after
    assign pop_first  = (cls_a == cls_ret);
    assign pop_second = (cls_b == cls_ret);

    // lcall still fetches its last byte in the low push cycle
    assign ret_low = pc[7:0] + {7'd0, rom_en};

    assign ram_wr_en   = advance & (push_low | push_high);
    assign ram_wr_addr = sp + 8'd1;
    assign ram_wr_byte = push_low ? ret_low : pc[15:8];

    // high byte first
    assign ram_rd_en   = advance & (pop_first | pop_second);
    assign ram_rd_addr = pop_first ? sp : sp - 8'd1;

    // valid in the cycle the low byte arrives
    assign pop_addr = {pop_high, ram_rd_byte};

    always_ff @(posedge clk) begin
        if (advance && pop_second) begin
            pop_high <= ram_rd_byte;
        end
    end

    // one step per push and both pops settled at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= sp_reset;
        end else if (advance) begin
            if (push_low || push_high) begin
                sp <= sp + 8'd1;
            end else if (pop_second) begin
                sp <= sp - 8'd2;
            end
        end
    end

    a_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(ram_rd_en && ram_wr_en)
    );

endmodule

/* hw/flow_core.sv */
`timescale 1ns/10ps

module flow_core import flow_core_pkg::*; #(
    parameter data_addr_t sp_reset = 8'h07,
    parameter code_addr_t pc_reset = 16'h0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_en,

    output logic       rom_en,
    output code_addr_t rom_addr,
    input  byte_t      rom_byte,

    output logic       ram_rd_en,
    output data_addr_t ram_rd_addr,
    input  byte_t      ram_rd_byte,
    input  logic       ram_rd_vld,

    output logic       ram_wr_en,
    output data_addr_t ram_wr_addr,
    output byte_t      ram_wr_byte
);

    logic       advance;
    phase_t     phase;
    byte_t      byte1;
    byte_t      byte2;
    op_class_t  cls_a;
    op_class_t  cls_b;
    op_class_t  cls_c;
    code_addr_t pc;
    code_addr_t pop_addr;

    fetch_sequencer u_fetch_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cpu_en     (cpu_en),
        .ram_rd_en  (ram_rd_en),
        .ram_rd_vld (ram_rd_vld),
        .cls_a      (cls_a),
        .advance    (advance),
        .phase      (phase)
    );

    instr_window u_instr_window (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .phase    (phase),
        .rom_byte (rom_byte),
        .byte1    (byte1),
        .byte2    (byte2),
        .cls_a    (cls_a),
        .cls_b    (cls_b),
        .cls_c    (cls_c)
    );

    program_counter #(
        .pc_reset (pc_reset)
    ) u_program_counter (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .rom_byte (rom_byte),
        .byte1    (byte1),
        .byte2    (byte2),
        .cls_a    (cls_a),
        .cls_b    (cls_b),
        .cls_c    (cls_c),
        .pop_addr (pop_addr),
        .pc       (pc),
        .rom_en   (rom_en),
        .rom_addr (rom_addr)
    );

    stack_unit #(
        .sp_reset (sp_reset)
    ) u_stack_unit (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .pc          (pc),
        .rom_en      (rom_en),
        .cls_a       (cls_a),
        .cls_b       (cls_b),
        .cls_c       (cls_c),
        .ram_rd_byte (ram_rd_byte),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_byte (ram_wr_byte),
        .pop_addr    (pop_addr)
    );

endmodule

/* test/tb_flow_core.sv */
`timescale 1ns/10ps

module tb_flow_core;

    localparam int num_instr = 400;
    localparam int clk_period = 20;
    localparam int cycle_limit = num_instr * 8 + 16;
    localparam logic [7:0] sp_start = 8'h30;
    localparam logic [15:0] pc_start = 16'h0100;

    logic        clk;
    logic        rst;
    logic        cpu_en;
    logic        rom_en;
    logic [15:0] rom_addr;
    logic [7:0]  rom_byte;
    logic        ram_rd_en;
    logic [7:0]  ram_rd_addr;
    logic [7:0]  ram_rd_byte;
    logic        ram_rd_vld;
    logic        ram_wr_en;
    logic [7:0]  ram_wr_addr;
    logic [7:0]  ram_wr_byte;

    logic [7:0]  rom [0:65535];
    logic [7:0]  ram [0:255];
    logic [7:0]  ref_ram [0:255];
    logic [15:0] exp_fetches [$];
    logic [7:0]  exp_reads [$];
    // address in the upper byte and data in the lower
    logic [15:0] exp_writes [$];

    logic [31:0] rng;
    int          error_count;
    logic        fetch_seen;
    logic [15:0] fetch_addr;
    // outstanding data read
    logic        rd_busy;
    logic        rd_taken;
    logic [7:0]  rd_addr_q;
    logic [31:0] rd_wait;

    flow_core #(
        .sp_reset (sp_start),
        .pc_reset (pc_start)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rom_byte    (rom_byte),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_byte (ram_rd_byte),
        .ram_rd_vld  (ram_rd_vld),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_byte (ram_wr_byte)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    task automatic abort_run();
        error_count++;
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
            abort_run();
        end
    endtask

    // code bytes lean toward the kept opcodes and small relative offsets
    task automatic fill_memories();
        logic [31:0] r;
        for (int a = 0; a < 65536; a++) begin
            draw_random(r);
            case (r[3:0])
                4'd5, 4'd6: rom[a] = 8'h80;
                4'd7:       rom[a] = {r[10:8], 5'b00001};
                4'd8:       rom[a] = {r[10:8], 5'b10001};
                4'd9:       rom[a] = 8'h02;
                4'd10:      rom[a] = 8'h12;
                4'd11:      rom[a] = 8'h22;
                4'd12:      rom[a] = 8'h32;
                4'd13, 4'd14, 4'd15: rom[a] = {{5{r[8]}}, r[11:9]};
                default:    rom[a] = r[15:8];
            endcase
        end
        for (int a = 0; a < 256; a++) begin
            draw_random(r);
            ram[a] = r[7:0];
            ref_ram[a] = r[7:0];
        end
    endtask

    task automatic push_return(inout logic [7:0] sp, input logic [15:0] next);
        sp = sp + 8'd1;
        ref_ram[sp] = next[7:0];
        exp_writes.push_back({sp, next[7:0]});
        sp = sp + 8'd1;
        ref_ram[sp] = next[15:8];
        exp_writes.push_back({sp, next[15:8]});
    endtask

    // instruction level model run once over the program
    task automatic run_reference();
        logic [15:0] pc;
        logic [15:0] next;
        logic [7:0]  sp;
        logic [7:0]  op;
        logic [7:0]  b2;
        logic [7:0]  b3;
        pc = pc_start;
        sp = sp_start;
        for (int i = 0; i < num_instr; i++) begin
            op = rom[pc];
            b2 = rom[pc + 16'd1];
            b3 = rom[pc + 16'd2];
            exp_fetches.push_back(pc);
            if (op == 8'h80) begin
                exp_fetches.push_back(pc + 16'd1);
                next = pc + 16'd2;
                pc = next + {{8{b2[7]}}, b2};
            end else if (op == 8'h02 || op == 8'h12) begin
                exp_fetches.push_back(pc + 16'd1);
                exp_fetches.push_back(pc + 16'd2);
                next = pc + 16'd3;
                if (op == 8'h12) begin
                    push_return(sp, next);
                end
                pc = {b2, b3};
            end else if (op == 8'h22 || op == 8'h32) begin
                exp_reads.push_back(sp);
                exp_reads.push_back(sp - 8'd1);
                pc = {ref_ram[sp], ref_ram[sp - 8'd1]};
                sp = sp - 8'd2;
            end else if (op[4:0] == 5'b00001 || op[4:0] == 5'b10001) begin
                exp_fetches.push_back(pc + 16'd1);
                next = pc + 16'd2;
                if (op[4]) begin
                    push_return(sp, next);
                end
                pc = {next[15:11], op[7:5], b2};
            end else begin
                pc = pc + 16'd1;
            end
        end
        // opcode fetch of the instruction after the last one
        exp_fetches.push_back(pc);
    endtask

    // runs just before the rising edge where outputs have settled
    task automatic sample_cycle();
        logic [15:0] wr_pair;
        logic [31:0] r;
        logic        stalled;
        stalled = rd_busy && !ram_rd_vld;
        if (!cpu_en || stalled) begin
            check_value("rom_en", 32'(rom_en), 32'd0);
            check_value("ram_rd_en", 32'(ram_rd_en), 32'd0);
            check_value("ram_wr_en", 32'(ram_wr_en), 32'd0);
        end
        fetch_seen = rom_en;
        fetch_addr = rom_addr;
        if (rom_en) begin
            check_value("rom_addr", 32'(rom_addr), 32'(exp_fetches.pop_front()));
        end
        if (ram_wr_en) begin
            if (exp_writes.size() == 0) begin
                $display("data memory write at %h with no write expected", ram_wr_addr);
                abort_run();
            end
            wr_pair = exp_writes.pop_front();
            check_value("ram_wr_addr", 32'(ram_wr_addr), 32'(wr_pair[15:8]));
            check_value("ram_wr_byte", 32'(ram_wr_byte), 32'(wr_pair[7:0]));
            ram[ram_wr_addr] = ram_wr_byte;
        end
        // data is taken at the first edge with vld and cpu_en both high
        rd_taken = rd_busy && ram_rd_vld && cpu_en;
        if (rd_taken) begin
            rd_busy = 1'b0;
        end
        if (ram_rd_en) begin
            if (exp_reads.size() == 0) begin
                $display("data memory read at %h with no read expected", ram_rd_addr);
                abort_run();
            end
            check_value("ram_rd_addr", 32'(ram_rd_addr), 32'(exp_reads.pop_front()));
            draw_random(r);
            rd_busy = 1'b1;
            rd_addr_q = ram_rd_addr;
            rd_wait = 32'd1 + (r % 32'd3);
        end
    endtask

    task automatic drive_inputs(input logic allow);
        logic [31:0] r;
        if (fetch_seen) begin
            rom_byte = rom[fetch_addr];
        end
        if (rd_taken) begin
            ram_rd_vld = 1'b0;
        end
        if (rd_busy && !ram_rd_vld) begin
            rd_wait = rd_wait - 32'd1;
            if (rd_wait == 32'd0) begin
                ram_rd_vld = 1'b1;
                ram_rd_byte = ram[rd_addr_q];
            end
        end
        draw_random(r);
        cpu_en = allow && (r[2:0] != 3'd0);
    endtask

    task automatic step_cycle(input logic allow);
        #(clk_period / 2 - 1);
        sample_cycle();
        @(negedge clk);
        drive_inputs(allow);
    endtask

    initial begin
        rst = 1'b1;
        cpu_en = 1'b0;
        rom_byte = 8'h00;
        ram_rd_byte = 8'h00;
        ram_rd_vld = 1'b0;
        rng = 32'h2f06;
        error_count = 0;
        fetch_seen = 1'b0;
        fetch_addr = 16'h0000;
        rd_busy = 1'b0;
        rd_taken = 1'b0;
        rd_addr_q = 8'h00;
        rd_wait = 32'd0;
        fill_memories();
        run_reference();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // core stays quiet until cpu_en rises
        repeat (4) step_cycle(1'b0);
        while (exp_fetches.size() != 0) begin
            step_cycle(1'b1);
        end
        if (exp_reads.size() != 0 || exp_writes.size() != 0) begin
            $display("run ended with %0d reads and %0d writes still expected",
                     exp_reads.size(), exp_writes.size());
            abort_run();
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (cycle_limit) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

/* flow_core.f */
hw/flow_core_pkg.sv
hw/fetch_sequencer.sv
hw/instr_window.sv
hw/program_counter.sv
hw/stack_unit.sv
hw/flow_core.sv
test/tb_flow_core.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_flow_core \
    -f flow_core.f \
    -o sim_flow_core

./obj_dir/sim_flow_core 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
